// File: hdl/icb_sram_pkg.sv
package icb_sram_pkg;

	// ICB bus widths
	localparam int ICB_ADDR_W = 32;
	localparam int ICB_DATA_W = 32;
	localparam int ICB_MASK_W = ICB_DATA_W / 8;

	// word index inside one bank, 1024 words of 4 bytes
	localparam int MEM_ADDR_W = 10;

	// memory map
	localparam int BANK_SEL_BIT = 12; // set selects bank 1
	localparam logic [ICB_ADDR_W-1:0] MAP_LIMIT = 32'h0000_2000; // first unmapped byte

	typedef logic [ICB_ADDR_W-1:0] icb_addr_t;
	typedef logic [ICB_DATA_W-1:0] icb_data_t;
	typedef logic [ICB_MASK_W-1:0] icb_mask_t; // bit i covers byte i
	typedef logic [ICB_ADDR_W-3:0] word_addr_t; // byte address without bits 1:0
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	// target of the one outstanding command in the decoder
	typedef enum logic [1:0]
	{
		ROUTE_IDLE  = 2'd0,
		ROUTE_BANK0 = 2'd1,
		ROUTE_BANK1 = 2'd2,
		ROUTE_ERR   = 2'd3
	} route_e;

endpackage

// File: hdl/sram_sp.sv
`timescale 1ns/1ps

module sram_sp (
	input  logic                   s_icb_aclk,
	input  logic                   mem_en,
	input  icb_sram_pkg::icb_mask_t  mem_wen,
	input  icb_sram_pkg::word_addr_t mem_addr,
	input  icb_sram_pkg::icb_data_t  mem_din,
	output icb_sram_pkg::icb_data_t  mem_dout
);
	import icb_sram_pkg::*;

	icb_data_t mem_array [0:(2**MEM_ADDR_W)-1];
	mem_addr_t word_idx;

	// bank size aliases the upper word address bits
	assign word_idx = mem_addr[MEM_ADDR_W-1:0];

	// byte lane writes
	always_ff @(posedge s_icb_aclk)
	begin
		if (mem_en)
		begin
			for (int i = 0; i < ICB_MASK_W; i++)
			begin
				if (mem_wen[i])
					mem_array[word_idx][8*i +: 8] <= mem_din[8*i +: 8];
			end
		end
	end

	// registered read port, holds its word between reads
	always_ff @(posedge s_icb_aclk)
	begin
		if (mem_en && (mem_wen == '0))
			mem_dout <= mem_array[word_idx]; // old contents, one cycle latency
	end

endmodule

// File: hdl/icb_sram_ctrler.sv
`timescale 1ns/1ps

module icb_sram_ctrler (
	input  logic                     s_icb_aclk,
	input  logic                     s_icb_aresetn,

	// ICB slave side
	input  icb_sram_pkg::icb_addr_t  cmd_addr,
	input  logic                     cmd_read,
	input  icb_sram_pkg::icb_data_t  cmd_wdata,
	input  icb_sram_pkg::icb_mask_t  cmd_wmask,
	input  logic                     cmd_valid,
	output logic                     cmd_ready,
	output icb_sram_pkg::icb_data_t  rsp_rdata,
	output logic                     rsp_valid,
	input  logic                     rsp_ready,

	// memory side
	output logic                     mem_en,
	output icb_sram_pkg::icb_mask_t  mem_wen,
	output icb_sram_pkg::word_addr_t mem_addr,
	output icb_sram_pkg::icb_data_t  mem_din,
	input  icb_sram_pkg::icb_data_t  mem_dout
);
	import icb_sram_pkg::*;

	logic      pending; // one transfer waiting for its response
	logic      cmd_hs;
	logic      rsp_hs;
	icb_mask_t align_mask;

	// free slot, or the pending response leaves this cycle
	assign cmd_ready = ~pending | rsp_ready;

	assign cmd_hs = cmd_valid & cmd_ready;
	assign rsp_hs = pending & rsp_ready;

	// unaligned writes drop the bytes below the start offset
	always_comb
	begin
		case (cmd_addr[1:0])
			2'b00:   align_mask = 4'b1111;
			2'b01:   align_mask = 4'b1110;
			2'b10:   align_mask = 4'b1100;
			default: align_mask = 4'b1000;
		endcase
	end

	assign mem_en   = cmd_hs; // single cycle strobe per command
	assign mem_wen  = cmd_read ? '0 : (cmd_wmask & align_mask);
	assign mem_addr = cmd_addr[ICB_ADDR_W-1:2];
	assign mem_din  = cmd_wdata;

	// only changes when exactly one handshake happens
	always_ff @(posedge s_icb_aclk or negedge s_icb_aresetn)
	begin
		if (!s_icb_aresetn)
			pending <= 1'b0;
		else if (cmd_hs ^ rsp_hs)
			pending <= cmd_hs;
	end

	assign rsp_valid = pending;

	// SRAM output holds while stalled since no access is issued
	assign rsp_rdata = mem_dout;

endmodule

// File: hdl/icb_addr_decoder.sv
`timescale 1ns/1ps

module icb_addr_decoder (
	input  logic                    s_icb_aclk,
	input  logic                    s_icb_aresetn,

	// upstream port
	input  icb_sram_pkg::icb_addr_t s_icb_cmd_addr,
	input  logic                    s_icb_cmd_read,
	input  icb_sram_pkg::icb_data_t s_icb_cmd_wdata,
	input  icb_sram_pkg::icb_mask_t s_icb_cmd_wmask,
	input  logic                    s_icb_cmd_valid,
	output logic                    s_icb_cmd_ready,
	output icb_sram_pkg::icb_data_t s_icb_rsp_rdata,
	output logic                    s_icb_rsp_err,
	output logic                    s_icb_rsp_valid,
	input  logic                    s_icb_rsp_ready,

	// bank 0 port
	output icb_sram_pkg::icb_addr_t b0_cmd_addr,
	output logic                    b0_cmd_read,
	output icb_sram_pkg::icb_data_t b0_cmd_wdata,
	output icb_sram_pkg::icb_mask_t b0_cmd_wmask,
	output logic                    b0_cmd_valid,
	input  logic                    b0_cmd_ready,
	input  icb_sram_pkg::icb_data_t b0_rsp_rdata,
	input  logic                    b0_rsp_valid,
	output logic                    b0_rsp_ready,

	// bank 1 port
	output icb_sram_pkg::icb_addr_t b1_cmd_addr,
	output logic                    b1_cmd_read,
	output icb_sram_pkg::icb_data_t b1_cmd_wdata,
	output icb_sram_pkg::icb_mask_t b1_cmd_wmask,
	output logic                    b1_cmd_valid,
	input  logic                    b1_cmd_ready,
	input  icb_sram_pkg::icb_data_t b1_rsp_rdata,
	input  logic                    b1_rsp_valid,
	output logic                    b1_rsp_ready
);
	import icb_sram_pkg::*;

	route_e route_q;  // target owing the next response
	route_e sel_route; // target of the command on the bus
	logic   sel_ready;
	logic   slot_free;
	logic   cmd_hs;
	logic   rsp_hs;

	// address classification
	always_comb
	begin
		if (s_icb_cmd_addr >= MAP_LIMIT)
			sel_route = ROUTE_ERR;
		else if (s_icb_cmd_addr[BANK_SEL_BIT])
			sel_route = ROUTE_BANK1;
		else
			sel_route = ROUTE_BANK0;
	end

	always_comb
	begin
		case (sel_route)
			ROUTE_BANK0: sel_ready = b0_cmd_ready;
			ROUTE_BANK1: sel_ready = b1_cmd_ready;
			default:     sel_ready = 1'b1; // error responder never stalls
		endcase
	end

	assign rsp_hs    = s_icb_rsp_valid & s_icb_rsp_ready;
	assign slot_free = (route_q == ROUTE_IDLE) | rsp_hs;

	assign s_icb_cmd_ready = slot_free & sel_ready;
	assign cmd_hs          = s_icb_cmd_valid & s_icb_cmd_ready;

	// payload goes to both banks, valid only to the chosen one
	assign b0_cmd_addr  = s_icb_cmd_addr;
	assign b0_cmd_read  = s_icb_cmd_read;
	assign b0_cmd_wdata = s_icb_cmd_wdata;
	assign b0_cmd_wmask = s_icb_cmd_wmask;
	assign b0_cmd_valid = s_icb_cmd_valid & slot_free & (sel_route == ROUTE_BANK0);

	assign b1_cmd_addr  = s_icb_cmd_addr;
	assign b1_cmd_read  = s_icb_cmd_read;
	assign b1_cmd_wdata = s_icb_cmd_wdata;
	assign b1_cmd_wmask = s_icb_cmd_wmask;
	assign b1_cmd_valid = s_icb_cmd_valid & slot_free & (sel_route == ROUTE_BANK1);

	// one command outstanding across all targets keeps order
	always_ff @(posedge s_icb_aclk or negedge s_icb_aresetn)
	begin
		if (!s_icb_aresetn)
			route_q <= ROUTE_IDLE;
		else if (cmd_hs)
			route_q <= sel_route;
		else if (rsp_hs)
			route_q <= ROUTE_IDLE;
	end

	// response mux
	assign b0_rsp_ready = s_icb_rsp_ready & (route_q == ROUTE_BANK0);
	assign b1_rsp_ready = s_icb_rsp_ready & (route_q == ROUTE_BANK1);

	always_comb
	begin
		case (route_q)
			ROUTE_BANK0:
			begin
				s_icb_rsp_valid = b0_rsp_valid;
				s_icb_rsp_rdata = b0_rsp_rdata;
			end
			ROUTE_BANK1:
			begin
				s_icb_rsp_valid = b1_rsp_valid;
				s_icb_rsp_rdata = b1_rsp_rdata;
			end
			ROUTE_ERR:
			begin
				s_icb_rsp_valid = 1'b1; // answers the cycle after acceptance
				s_icb_rsp_rdata = '0;
			end
			default:
			begin
				s_icb_rsp_valid = 1'b0;
				s_icb_rsp_rdata = '0;
			end
		endcase
	end

	assign s_icb_rsp_err = (route_q == ROUTE_ERR);

endmodule

// File: hdl/icb_sram_subsys.sv
`timescale 1ns/1ps

module icb_sram_subsys (
	input  logic                    s_icb_aclk,
	input  logic                    s_icb_aresetn,

	input  icb_sram_pkg::icb_addr_t s_icb_cmd_addr,
	input  logic                    s_icb_cmd_read,
	input  icb_sram_pkg::icb_data_t s_icb_cmd_wdata,
	input  icb_sram_pkg::icb_mask_t s_icb_cmd_wmask,
	input  logic                    s_icb_cmd_valid,
	output logic                    s_icb_cmd_ready,
	output icb_sram_pkg::icb_data_t s_icb_rsp_rdata,
	output logic                    s_icb_rsp_err,
	output logic                    s_icb_rsp_valid,
	input  logic                    s_icb_rsp_ready
);
	import icb_sram_pkg::*;

	// decoder to bank 0 controller
	icb_addr_t  b0_cmd_addr;
	logic       b0_cmd_read;
	icb_data_t  b0_cmd_wdata;
	icb_mask_t  b0_cmd_wmask;
	logic       b0_cmd_valid;
	logic       b0_cmd_ready;
	icb_data_t  b0_rsp_rdata;
	logic       b0_rsp_valid;
	logic       b0_rsp_ready;

	// decoder to bank 1 controller
	icb_addr_t  b1_cmd_addr;
	logic       b1_cmd_read;
	icb_data_t  b1_cmd_wdata;
	icb_mask_t  b1_cmd_wmask;
	logic       b1_cmd_valid;
	logic       b1_cmd_ready;
	icb_data_t  b1_rsp_rdata;
	logic       b1_rsp_valid;
	logic       b1_rsp_ready;

	// controller to SRAM strobes
	logic       mem0_en;
	icb_mask_t  mem0_wen;
	word_addr_t mem0_addr;
	icb_data_t  mem0_din;
	icb_data_t  mem0_dout;
	logic       mem1_en;
	icb_mask_t  mem1_wen;
	word_addr_t mem1_addr;
	icb_data_t  mem1_din;
	icb_data_t  mem1_dout;

	icb_addr_decoder u_decoder (
		.s_icb_aclk, .s_icb_aresetn,
		.s_icb_cmd_addr, .s_icb_cmd_read, .s_icb_cmd_wdata, .s_icb_cmd_wmask,
		.s_icb_cmd_valid, .s_icb_cmd_ready,
		.s_icb_rsp_rdata, .s_icb_rsp_err, .s_icb_rsp_valid, .s_icb_rsp_ready,
		.b0_cmd_addr, .b0_cmd_read, .b0_cmd_wdata, .b0_cmd_wmask,
		.b0_cmd_valid, .b0_cmd_ready, .b0_rsp_rdata, .b0_rsp_valid, .b0_rsp_ready,
		.b1_cmd_addr, .b1_cmd_read, .b1_cmd_wdata, .b1_cmd_wmask,
		.b1_cmd_valid, .b1_cmd_ready, .b1_rsp_rdata, .b1_rsp_valid, .b1_rsp_ready
	);

	icb_sram_ctrler u_ctrl0 (
		.s_icb_aclk, .s_icb_aresetn,
		.cmd_addr(b0_cmd_addr), .cmd_read(b0_cmd_read), .cmd_wdata(b0_cmd_wdata),
		.cmd_wmask(b0_cmd_wmask), .cmd_valid(b0_cmd_valid), .cmd_ready(b0_cmd_ready),
		.rsp_rdata(b0_rsp_rdata), .rsp_valid(b0_rsp_valid), .rsp_ready(b0_rsp_ready),
		.mem_en(mem0_en), .mem_wen(mem0_wen), .mem_addr(mem0_addr),
		.mem_din(mem0_din), .mem_dout(mem0_dout)
	);

	icb_sram_ctrler u_ctrl1 (
		.s_icb_aclk, .s_icb_aresetn,
		.cmd_addr(b1_cmd_addr), .cmd_read(b1_cmd_read), .cmd_wdata(b1_cmd_wdata),
		.cmd_wmask(b1_cmd_wmask), .cmd_valid(b1_cmd_valid), .cmd_ready(b1_cmd_ready),
		.rsp_rdata(b1_rsp_rdata), .rsp_valid(b1_rsp_valid), .rsp_ready(b1_rsp_ready),
		.mem_en(mem1_en), .mem_wen(mem1_wen), .mem_addr(mem1_addr),
		.mem_din(mem1_din), .mem_dout(mem1_dout)
	);

	sram_sp u_sram0 (
		.s_icb_aclk, .mem_en(mem0_en), .mem_wen(mem0_wen), .mem_addr(mem0_addr),
		.mem_din(mem0_din), .mem_dout(mem0_dout)
	);

	sram_sp u_sram1 (
		.s_icb_aclk, .mem_en(mem1_en), .mem_wen(mem1_wen), .mem_addr(mem1_addr),
		.mem_din(mem1_din), .mem_dout(mem1_dout)
	);

endmodule

// File: dv/icb_sram_checker.sv
`timescale 1ns/1ps

module icb_sram_checker (
	input  logic        s_icb_aclk,
	input  logic        s_icb_aresetn,
	input  logic [31:0] s_icb_cmd_addr,
	input  logic        s_icb_cmd_read,
	input  logic [31:0] s_icb_cmd_wdata,
	input  logic [3:0]  s_icb_cmd_wmask,
	input  logic        s_icb_cmd_valid,
	input  logic        s_icb_cmd_ready,
	input  logic [31:0] s_icb_rsp_rdata,
	input  logic        s_icb_rsp_err,
	input  logic        s_icb_rsp_valid,
	input  logic        s_icb_rsp_ready,
	output int          error_cnt,
	output int          rsp_cnt,
	output int          outstanding
);
	localparam logic [31:0] UNMAPPED_BASE = 32'h0000_2000;

	logic [31:0] bank0_model [0:1023];
	logic [31:0] bank1_model [0:1023];
	logic [33:0] exp_q [$]; // {read, err, rdata} in command order
	int          errors = 0;
	int          rsps   = 0;
	int          depth  = 0;

	assign error_cnt   = errors;
	assign rsp_cnt     = rsps;
	assign outstanding = depth;

	// expected response of one command, writes update the model
	function automatic void ref_access(
		input  logic [31:0] addr,
		input  logic        read,
		input  logic [31:0] wdata,
		input  logic [3:0]  wmask,
		output logic [31:0] exp_rdata,
		output logic        exp_err
	);
		logic [31:0] word;
		logic [9:0]  idx;
		idx       = addr[11:2];
		exp_rdata = '0;
		exp_err   = (addr >= UNMAPPED_BASE);
		if (!exp_err)
		begin
			word = addr[12] ? bank1_model[idx] : bank0_model[idx];
			if (read)
				exp_rdata = word;
			else
			begin
				for (int i = 0; i < 4; i++)
				begin
					if (wmask[i] && (i >= addr[1:0])) // bytes below the offset stay
						word[8*i +: 8] = wdata[8*i +: 8];
				end
				if (addr[12])
					bank1_model[idx] = word;
				else
					bank0_model[idx] = word;
			end
		end
	endfunction

	always @(posedge s_icb_aclk)
	begin
		logic [33:0] entry;
		logic [31:0] exp_rdata;
		logic        exp_err;
		if (s_icb_aresetn)
		begin
			// the response always belongs to an earlier command
			if (s_icb_rsp_valid && s_icb_rsp_ready)
			begin
				if (exp_q.size() == 0)
				begin
					$display("%0t: response arrived with no command outstanding", $time);
					errors++;
				end
				else
				begin
					entry = exp_q.pop_front();
					rsps++;
					if (entry[32] !== s_icb_rsp_err)
					begin
						$display("[ERROR] %0t s_icb_rsp_err expected %0b got %0b",
							$time, entry[32], s_icb_rsp_err);
						errors++;
					end
					if (entry[33] && (entry[31:0] !== s_icb_rsp_rdata))
					begin
						$display("[ERROR] %0t s_icb_rsp_rdata expected %08h got %08h",
							$time, entry[31:0], s_icb_rsp_rdata);
						errors++;
					end
				end
			end
			if (s_icb_cmd_valid && s_icb_cmd_ready)
			begin
				ref_access(s_icb_cmd_addr, s_icb_cmd_read, s_icb_cmd_wdata,
					s_icb_cmd_wmask, exp_rdata, exp_err);
				exp_q.push_back({s_icb_cmd_read, exp_err, exp_rdata});
			end
			depth = exp_q.size();
		end
	end

endmodule

// File: dv/icb_sram_sva.sv
`timescale 1ns/1ps

module icb_sram_sva (
	input logic        s_icb_aclk,
	input logic        s_icb_aresetn,
	input logic        s_icb_cmd_valid,
	input logic        s_icb_cmd_ready,
	input logic [31:0] s_icb_rsp_rdata,
	input logic        s_icb_rsp_err,
	input logic        s_icb_rsp_valid,
	input logic        s_icb_rsp_ready
);

	int fail_cnt = 0; // assertion failures so far

	// stalled response holds its payload
	a_rsp_stable: assert property (@(posedge s_icb_aclk) disable iff (!s_icb_aresetn)
		(s_icb_rsp_valid && !s_icb_rsp_ready) |=>
			(s_icb_rsp_valid && $stable(s_icb_rsp_rdata) && $stable(s_icb_rsp_err)))
		else
		begin
			$error("response changed or dropped while stalled");
			fail_cnt++;
		end

	a_rsp_next: assert property (@(posedge s_icb_aclk) disable iff (!s_icb_aresetn)
		(s_icb_cmd_valid && s_icb_cmd_ready) |=> s_icb_rsp_valid)
		else
		begin
			$error("no response in the cycle after a command handshake");
			fail_cnt++;
		end

	a_rsp_reset: assert property (@(posedge s_icb_aclk)
		!s_icb_aresetn |-> !s_icb_rsp_valid)
		else
		begin
			$error("rsp_valid high during reset");
			fail_cnt++;
		end

endmodule

bind icb_sram_subsys icb_sram_sva u_sva (
	.s_icb_aclk, .s_icb_aresetn, .s_icb_cmd_valid, .s_icb_cmd_ready,
	.s_icb_rsp_rdata, .s_icb_rsp_err, .s_icb_rsp_valid, .s_icb_rsp_ready
);

// File: dv/tb_icb_sram_subsys.sv
`timescale 1ns/1ps

module tb_icb_sram_subsys;
	localparam int          NUM_OPS = 400;
	localparam int          TIMEOUT = 200; // cycles per wait
	localparam logic [31:0] SEED    = 32'hdb48_ea78;

	logic        s_icb_aclk;
	logic        s_icb_aresetn;
	logic [31:0] s_icb_cmd_addr;
	logic        s_icb_cmd_read;
	logic [31:0] s_icb_cmd_wdata;
	logic [3:0]  s_icb_cmd_wmask;
	logic        s_icb_cmd_valid;
	logic        s_icb_cmd_ready;
	logic [31:0] s_icb_rsp_rdata;
	logic        s_icb_rsp_err;
	logic        s_icb_rsp_valid;
	logic        s_icb_rsp_ready;

	int          check_errors;
	int          rsp_count;
	int          outstanding;
	int          sva_errors   = 0;
	int          drv_errors   = 0;
	logic        timed_out    = 1'b0;
	logic        no_stall     = 1'b0; // every command taken on its first edge
	logic        backpressure = 1'b0;
	logic [31:0] cmd_state    = SEED;
	logic [31:0] rsp_state    = ~SEED; // own stream for rsp_ready
	logic [31:0] unmapped [4] = '{32'h0000_2000, 32'h0000_3000, 32'h8000_1000, 32'hffff_fffc};

	icb_sram_subsys u_icb_sram_subsys (.*);

	icb_sram_checker u_checker (.*, .error_cnt(check_errors), .rsp_cnt(rsp_count));

	initial
	begin
		s_icb_aclk = 1'b0;
		forever #4 s_icb_aclk = ~s_icb_aclk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		cmd_state = xorshift(cmd_state);
		return cmd_state;
	endfunction

	// word idx of the test pool in one bank
	function automatic logic [31:0] pool_addr(input int bank, input int idx);
		return (32'(bank) << 12) | (32'(idx) << 2);
	endfunction

	task automatic send_cmd(input logic [31:0] addr, input logic read,
		input logic [31:0] wdata, input logic [3:0] wmask);
		int waited;
		waited = 0;
		if (!timed_out)
		begin
			@(negedge s_icb_aclk);
			s_icb_cmd_addr  = addr;
			s_icb_cmd_read  = read;
			s_icb_cmd_wdata = wdata;
			s_icb_cmd_wmask = wmask;
			s_icb_cmd_valid = 1'b1;
			@(posedge s_icb_aclk);
			while (!s_icb_cmd_ready && waited < TIMEOUT)
			begin
				waited++;
				@(posedge s_icb_aclk);
			end
			if (!s_icb_cmd_ready)
			begin
				$display("%0t: command to %08h not accepted within %0d cycles",
					$time, addr, TIMEOUT);
				drv_errors++;
				timed_out = 1'b1;
			end
			else if (no_stall && waited != 0)
			begin
				$display("%0t: command to %08h stalled %0d cycles with rsp_ready high",
					$time, addr, waited);
				drv_errors++;
			end
		end
	endtask

	task automatic idle_bus();
		@(negedge s_icb_aclk);
		s_icb_cmd_valid = 1'b0;
	endtask

	task automatic drain_responses();
		int waited;
		waited = 0;
		idle_bus();
		while (outstanding != 0 && waited < TIMEOUT)
		begin
			waited++;
			@(negedge s_icb_aclk);
		end
		if (outstanding != 0)
		begin
			$display("%0t: %0d responses never arrived", $time, outstanding);
			drv_errors++;
			timed_out = 1'b1;
		end
	endtask

	// random low periods of rsp_ready, up to 8 cycles each
	initial
	begin
		int low;
		s_icb_rsp_ready = 1'b1;
		forever
		begin
			@(negedge s_icb_aclk);
			rsp_state = xorshift(rsp_state);
			if (backpressure && rsp_state[1:0] == 2'b00)
			begin
				s_icb_rsp_ready = 1'b0;
				low = int'(rsp_state[4:2]) + 1;
				repeat (low) @(negedge s_icb_aclk);
				s_icb_rsp_ready = 1'b1;
			end
		end
	end

	initial
	begin
		logic [31:0] r;
		logic [31:0] addr;
		s_icb_aresetn   = 1'b1;
		s_icb_cmd_addr  = '0;
		s_icb_cmd_read  = 1'b0;
		s_icb_cmd_wdata = '0;
		s_icb_cmd_wmask = '0;
		s_icb_cmd_valid = 1'b0;
		#1 s_icb_aresetn = 1'b0;
		repeat (4) @(posedge s_icb_aclk);
		@(negedge s_icb_aclk);
		s_icb_aresetn = 1'b1;

		// fill and read back 16 words per bank, one command per cycle
		no_stall = 1'b1;
		for (int i = 0; i < 32; i++)
			send_cmd(pool_addr(i / 16, i % 16), 1'b0, next_rand(), 4'b1111);
		for (int i = 0; i < 32; i++)
			send_cmd(pool_addr(i / 16, i % 16), 1'b1, '0, 4'b0000);

		for (int b = 0; b < 2; b++)
		begin
			for (int off = 1; off < 4; off++)
			begin
				send_cmd(pool_addr(b, 3), 1'b0, 32'h1122_3344, 4'b1111);
				send_cmd(pool_addr(b, 3) + off, 1'b0, 32'haabb_ccdd, 4'b1111);
				send_cmd(pool_addr(b, 3), 1'b1, '0, 4'b0000);
			end
		end

		// same index, other bank
		send_cmd(pool_addr(0, 5), 1'b0, 32'h0000_b0b0, 4'b1111);
		send_cmd(pool_addr(1, 5), 1'b0, 32'h0000_b1b1, 4'b1111);
		send_cmd(pool_addr(0, 5), 1'b1, '0, 4'b0000);
		send_cmd(pool_addr(1, 5), 1'b1, '0, 4'b0000);

		for (int k = 0; k < 4; k++)
		begin
			send_cmd(unmapped[k], 1'b0, next_rand(), 4'b1111);
			send_cmd(unmapped[k], 1'b1, '0, 4'b0000);
		end
		send_cmd(pool_addr(0, 0), 1'b1, '0, 4'b0000); // aliases of word 0
		send_cmd(pool_addr(1, 0), 1'b1, '0, 4'b0000);
		drain_responses();

		no_stall = 1'b0;
		@(posedge s_icb_aclk);
		backpressure = 1'b1;
		for (int n = 0; n < NUM_OPS && !timed_out; n++)
		begin
			r = next_rand();
			if (r[2:0] == 3'd0)
				addr = 32'h0000_2000 | next_rand(); // unmapped
			else
				addr = pool_addr(r[3], r[7:4]) | r[9:8];
			send_cmd(addr, r[10], next_rand(), r[14:11]);
			if (r[17:15] == 3'd0)
				idle_bus();
		end
		drain_responses();

		sva_errors = u_icb_sram_subsys.u_sva.fail_cnt;
		$display("checker errors %0d, assertion errors %0d, driver errors %0d, responses checked %0d",
			check_errors, sva_errors, drv_errors, rsp_count);
		if (check_errors == 0 && sva_errors == 0 && drv_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: flist.f
hdl/icb_sram_pkg.sv
hdl/sram_sp.sv
hdl/icb_sram_ctrler.sv
hdl/icb_addr_decoder.sv
hdl/icb_sram_subsys.sv
dv/icb_sram_checker.sv
dv/icb_sram_sva.sv
dv/tb_icb_sram_subsys.sv

// File: Bender.yml
package:
  name: icb_sram_subsys

sources:
  - files:
      - hdl/icb_sram_pkg.sv
      - hdl/sram_sp.sv
      - hdl/icb_sram_ctrler.sv
      - hdl/icb_addr_decoder.sv
      - hdl/icb_sram_subsys.sv
  - target: test
    files:
      - dv/icb_sram_checker.sv
      - dv/icb_sram_sva.sv
      - dv/tb_icb_sram_subsys.sv
